/* hw/deskew_settings.svh */
`ifndef DESKEW_SETTINGS_SVH
`define DESKEW_SETTINGS_SVH

// Pixel and image geometry
`define DESKEW_PIX_W     8
`define DESKEW_DIM_W     9
`define DESKEW_ADDR_W    17

// Moment sums, exact up to 64x64 images
`define DESKEW_MOMENT_W  29

// Centroid in unsigned 10.3
`define DESKEW_FRAC_W    3
`define DESKEW_CENT_W    13

// Decoupling FIFOs hold 8 entries
`define DESKEW_FIFO_AW   3

`endif

/* hw/moment_pkg.sv */
`include "deskew_settings.svh"

package moment_pkg;

   typedef logic [`DESKEW_PIX_W-1:0]    pix_t;
   typedef logic [`DESKEW_DIM_W-1:0]    coord_t;
   typedef logic [`DESKEW_ADDR_W-1:0]   addr_t;
   typedef logic [`DESKEW_MOMENT_W-1:0] moment_t;
   typedef logic [`DESKEW_CENT_W-1:0]   cent_t;

   // Host configuration, one per request
   typedef struct packed {
      coord_t img_dim;
      addr_t  start_addr;
   } img_cfg_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
   } coord_pair_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } mem_rd_t;

   typedef struct packed {
      moment_t m00;
      moment_t m10;
      moment_t m01;
   } moments_t;

   typedef struct packed {
      cent_t x_mc;
      cent_t y_mc;
   } centroid_t;

endpackage

/* hw/cfg_regs.sv */
`timescale 1ns/100ps

module cfg_regs import moment_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     req_i,
   input  img_cfg_t cfg_i,
   input  logic     cent_valid_i,
   output logic     ack_o,
   output img_cfg_t cfg_o,
   output logic     start_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_busy,
      st_ack,
      st_release
   } state_t;

   state_t state;

   //////////////////////////////
   // Four-phase handshake FSM
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= st_idle;
         start_o <= 1'b0;
      end
      else
      begin
         start_o <= 1'b0;
         case (state)
            st_idle:
               if (req_i)
               begin
                  state   <= st_busy;
                  start_o <= 1'b1;
               end
            st_busy:
               if (cent_valid_i)
                  state <= st_ack;
            st_ack:
               if (!req_i)
                  state <= st_release;
            default:
               state <= st_idle;
         endcase
      end
   end

   // Captured once per request, held for the whole run
   always_ff @(posedge clk)
   begin
      if (state == st_idle && req_i)
         cfg_o <= cfg_i;
   end

   assign ack_o = (state == st_ack);

   // No relaunch once a run is underway
   assert property (@(posedge clk) disable iff (!rst_n)
      (state == st_busy && $past(state) == st_busy) |-> !start_o);

   // Host must drop req first
   assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ack_o) |-> !$past(req_i));

endmodule

/* hw/raster_addr_gen.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module raster_addr_gen import moment_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start_i,
   input  img_cfg_t                 cfg_i,
   input  logic [`DESKEW_FIFO_AW:0] pix_fifo_cnt_i,
   output mem_rd_t                  mem_rd_o,
   output coord_pair_t              coord_o,
   output logic                     coord_push_o,
   output logic                     pix_push_o
);

   // Leaves a slot for the read still in flight
   localparam int room_max = (1 << `DESKEW_FIFO_AW) - 2;

   logic   active;
   coord_t x_cnt;
   coord_t y_cnt;
   addr_t  row_base;
   logic   issue;
   logic   last_col;
   logic   last_row;

   assign issue    = active && (pix_fifo_cnt_i <= room_max);
   assign last_col = (x_cnt == cfg_i.img_dim - 1'b1);
   assign last_row = (y_cnt == cfg_i.img_dim - 1'b1);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active     <= 1'b0;
         x_cnt      <= '0;
         y_cnt      <= '0;
         row_base   <= '0;
         pix_push_o <= 1'b0;
      end
      else
      begin
         // Memory answers one cycle after the read
         pix_push_o <= issue;
         if (start_i)
         begin
            active   <= 1'b1;
            x_cnt    <= '0;
            y_cnt    <= '0;
            row_base <= '0;
         end
         else if (issue)
         begin
            if (last_col)
            begin
               x_cnt <= '0;
               if (last_row)
                  active <= 1'b0;
               else
               begin
                  y_cnt    <= y_cnt + 1'b1;
                  row_base <= row_base + cfg_i.img_dim;
               end
            end
            else
               x_cnt <= x_cnt + 1'b1;
         end
      end
   end

   // Row base tracks y * img_dim
   assign mem_rd_o.en   = issue;
   assign mem_rd_o.addr = cfg_i.start_addr + row_base + addr_t'(x_cnt);
   assign coord_o.x     = x_cnt;
   assign coord_o.y     = y_cnt;
   assign coord_push_o  = issue;

   // Reads stay inside the image window
   assert property (@(posedge clk) disable iff (!rst_n)
      mem_rd_o.en |-> (mem_rd_o.addr - cfg_i.start_addr) <=
         (addr_t'(cfg_i.img_dim) * addr_t'(cfg_i.img_dim) - 1'b1));

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module sync_fifo import moment_pkg::*;
#(
   parameter type payload_t = pix_t
)
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     clr_i,
   input  logic                     push_i,
   input  payload_t                 data_i,
   input  logic                     pop_i,
   output payload_t                 data_o,
   output logic                     empty_o,
   output logic [`DESKEW_FIFO_AW:0] count_o
);

   localparam int depth = 1 << `DESKEW_FIFO_AW;

   payload_t                   mem [depth];
   logic [`DESKEW_FIFO_AW-1:0] wr_ptr;
   logic [`DESKEW_FIFO_AW-1:0] rd_ptr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end
      else if (clr_i)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_i, pop_i})
            2'b10:
               count_o <= count_o + 1'b1;
            2'b01:
               count_o <= count_o - 1'b1;
            default:
               count_o <= count_o;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_i && !clr_i)
         mem[wr_ptr] <= data_i;
   end

   // Head of queue, visible the cycle after the write
   assign data_o  = mem[rd_ptr];
   assign empty_o = (count_o == '0);

   assert property (@(posedge clk) disable iff (!rst_n)
      push_i |-> (count_o < depth));

   assert property (@(posedge clk) disable iff (!rst_n)
      pop_i |-> !empty_o);

endmodule

/* hw/moment_accum.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module moment_accum import moment_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        start_i,
   input  coord_t      img_dim_i,
   input  pix_t        pix_i,
   input  coord_pair_t coord_i,
   input  logic        pix_empty_i,
   input  logic        coord_empty_i,
   output logic        pop_o,
   output moments_t    moments_o,
   output logic        sums_done_o
);

   localparam int cnt_w = 2 * `DESKEW_DIM_W;

   logic [cnt_w-1:0] pix_cnt;
   logic [cnt_w-1:0] pix_total;
   logic             last_pop;
   moment_t          x_prod;
   moment_t          y_prod;

   // Both FIFOs move together, pixel side decides
   assign pop_o     = !pix_empty_i;
   assign pix_total = img_dim_i * img_dim_i;
   assign last_pop  = pop_o && (pix_cnt + 1'b1 == pix_total);

   assign x_prod = coord_i.x * pix_i;
   assign y_prod = coord_i.y * pix_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pix_cnt     <= '0;
         moments_o   <= '0;
         sums_done_o <= 1'b0;
      end
      else if (start_i)
      begin
         pix_cnt     <= '0;
         moments_o   <= '0;
         sums_done_o <= 1'b0;
      end
      else
      begin
         // Pulse with the final update
         sums_done_o <= last_pop;
         if (pop_o)
         begin
            pix_cnt       <= pix_cnt + 1'b1;
            moments_o.m00 <= moments_o.m00 + pix_i;
            moments_o.m10 <= moments_o.m10 + x_prod;
            moments_o.m01 <= moments_o.m01 + y_prod;
         end
      end
   end

   // Coordinates go in a cycle before their pixel
   assert property (@(posedge clk) disable iff (!rst_n)
      !pix_empty_i |-> !coord_empty_i);

endmodule

/* hw/centroid_divider.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module centroid_divider import moment_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      start_i,
   input  moments_t  moments_i,
   output centroid_t centroid_o,
   output logic      valid_o
);

   localparam int div_w  = `DESKEW_MOMENT_W + `DESKEW_FRAC_W;
   localparam int step_w = $clog2(2 * div_w);

   logic                    busy;
   logic [step_w-1:0]       step;
   logic                    zero_div;
   moment_t                 divisor_q;
   moment_t                 m01_q;
   moment_t                 rem_q;
   logic [div_w-1:0]        dvd_q;
   logic [`DESKEW_MOMENT_W:0] trial;
   moment_t                 rem_next;
   logic                    q_bit;
   logic [div_w-1:0]        quot_next;
   cent_t                   quot_cent;

   //////////////////////////////
   // Restoring step
   //////////////////////////////

   always_comb
   begin
      trial     = {rem_q, dvd_q[div_w-1]};
      q_bit     = (trial >= {1'b0, divisor_q});
      rem_next  = q_bit ? moment_t'(trial - {1'b0, divisor_q}) : moment_t'(trial);
      quot_next = {dvd_q[div_w-2:0], q_bit};
   end

   // Zero mass maps to the origin
   assign quot_cent = zero_div ? '0 : quot_next[`DESKEW_CENT_W-1:0];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy    <= 1'b0;
         step    <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         valid_o <= 1'b0;
         if (start_i)
         begin
            busy <= 1'b1;
            step <= '0;
         end
         else if (busy)
         begin
            step <= step + 1'b1;
            if (step == step_w'(2 * div_w - 1))
            begin
               busy    <= 1'b0;
               valid_o <= 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // Operands and quotients
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (start_i)
      begin
         divisor_q <= moments_i.m00;
         m01_q     <= moments_i.m01;
         zero_div  <= (moments_i.m00 == '0);
         rem_q     <= '0;
         dvd_q     <= {moments_i.m10, {`DESKEW_FRAC_W{1'b0}}};
      end
      else if (busy)
      begin
         if (step == step_w'(div_w - 1))
         begin
            // x finished, y reuses the same datapath
            centroid_o.x_mc <= quot_cent;
            rem_q           <= '0;
            dvd_q           <= {m01_q, {`DESKEW_FRAC_W{1'b0}}};
         end
         else
         begin
            rem_q <= rem_next;
            dvd_q <= quot_next;
         end
         if (step == step_w'(2 * div_w - 1))
            centroid_o.y_mc <= quot_cent;
      end
   end

endmodule

/* hw/moment_engine_top.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module moment_engine_top import moment_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      req_i,
   input  img_cfg_t  cfg_i,
   output logic      ack_o,
   output mem_rd_t   mem_rd_o,
   input  pix_t      rdata_i,
   output moments_t  moments_o,
   output centroid_t centroid_o
);

   img_cfg_t                 cfg;
   logic                     start;
   logic                     cent_valid;
   coord_pair_t              coord_wr;
   coord_pair_t              coord_rd;
   logic                     coord_push;
   logic                     coord_empty;
   logic                     pix_push;
   pix_t                     pix_rd;
   logic                     pix_empty;
   logic [`DESKEW_FIFO_AW:0] pix_cnt;
   logic                     pop;
   logic                     sums_done;

   cfg_regs u_cfg_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_i        (req_i),
      .cfg_i        (cfg_i),
      .cent_valid_i (cent_valid),
      .ack_o        (ack_o),
      .cfg_o        (cfg),
      .start_o      (start)
   );

   raster_addr_gen u_raster_addr_gen (
      .clk            (clk),
      .rst_n          (rst_n),
      .start_i        (start),
      .cfg_i          (cfg),
      .pix_fifo_cnt_i (pix_cnt),
      .mem_rd_o       (mem_rd_o),
      .coord_o        (coord_wr),
      .coord_push_o   (coord_push),
      .pix_push_o     (pix_push)
   );

   //////////////////////////////
   // Decoupling FIFOs
   //////////////////////////////

   sync_fifo #(.payload_t(coord_pair_t)) u_coord_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .clr_i   (start),
      .push_i  (coord_push),
      .data_i  (coord_wr),
      .pop_i   (pop),
      .data_o  (coord_rd),
      .empty_o (coord_empty),
      .count_o ()
   );

   sync_fifo #(.payload_t(pix_t)) u_pix_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .clr_i   (start),
      .push_i  (pix_push),
      .data_i  (rdata_i),
      .pop_i   (pop),
      .data_o  (pix_rd),
      .empty_o (pix_empty),
      .count_o (pix_cnt)
   );

   moment_accum u_moment_accum (
      .clk           (clk),
      .rst_n         (rst_n),
      .start_i       (start),
      .img_dim_i     (cfg.img_dim),
      .pix_i         (pix_rd),
      .coord_i       (coord_rd),
      .pix_empty_i   (pix_empty),
      .coord_empty_i (coord_empty),
      .pop_o         (pop),
      .moments_o     (moments_o),
      .sums_done_o   (sums_done)
   );

   centroid_divider u_centroid_divider (
      .clk        (clk),
      .rst_n      (rst_n),
      .start_i    (sums_done),
      .moments_i  (moments_o),
      .centroid_o (centroid_o),
      .valid_o    (cent_valid)
   );

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // Reset held for three rising edges
   initial
   begin
      rst_n = 1'b0;
      repeat (3)
         @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

/* testbench/tb_pixel_mem.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module tb_pixel_mem import moment_pkg::*;
(
   input  logic    clk,
   input  mem_rd_t mem_rd_i,
   output pix_t    rdata_o
);

   localparam int mem_words = 1 << `DESKEW_ADDR_W;

   pix_t mem [mem_words];

   // Background content, every address bit has its say
   function automatic pix_t background(input addr_t a);
      return pix_t'(a[7:0] ^ a[15:8] ^ {a[16], 7'b0000000});
   endfunction

   initial
   begin
      rdata_o = '0;
      for (int a = 0; a < mem_words; a++)
         mem[a] = background(addr_t'(a));
   end

   // Data comes back one cycle after the read
   always @(posedge clk)
   begin
      if (mem_rd_i.en)
         rdata_o <= mem[mem_rd_i.addr];
   end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/100ps
`include "deskew_settings.svh"

module tb_top import moment_pkg::*;
();

   localparam int mem_words   = 1 << `DESKEW_ADDR_W;
   localparam int ack_timeout = 6000;
   localparam int fall_limit  = 8;
   localparam int reset_limit = 20;
   localparam int hold_cycles = 3;
   localparam int margin      = 48;
   localparam int const_pix   = 200;

   typedef enum logic [1:0] {
      pat_ramp,
      pat_const,
      pat_zero,
      pat_random
   } pattern_t;

   typedef struct packed {
      coord_t   img_dim;
      addr_t    start_addr;
      pattern_t pattern;
   } test_entry_t;

   logic      clk;
   logic      rst_n;
   logic      req;
   img_cfg_t  cfg;
   logic      ack;
   mem_rd_t   mem_rd;
   pix_t      rdata;
   moments_t  moments;
   centroid_t centroid;

   test_entry_t table_q [$];
   integer      seed;
   int          errors;
   int          tests_run;
   int          tests_failed;

   logic  window_on;
   addr_t window_lo;
   addr_t window_hi;
   int    read_count;
   int    stray_reads;

   tb_clk_gen clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   tb_pixel_mem mem_model (
      .clk      (clk),
      .mem_rd_i (mem_rd),
      .rdata_o  (rdata)
   );

   moment_engine_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_i      (req),
      .cfg_i      (cfg),
      .ack_o      (ack),
      .mem_rd_o   (mem_rd),
      .rdata_i    (rdata),
      .moments_o  (moments),
      .centroid_o (centroid)
   );

   // Counts reads and those outside the image window
   always @(posedge clk)
   begin
      if (window_on && mem_rd.en)
      begin
         read_count = read_count + 1;
         if (mem_rd.addr < window_lo || mem_rd.addr > window_hi)
            stray_reads = stray_reads + 1;
      end
   end

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   task automatic add_test(input int dim, input int addr, input pattern_t pat);
      test_entry_t t;
      t.img_dim    = coord_t'(dim);
      t.start_addr = addr_t'(addr);
      t.pattern    = pat;
      table_q.push_back(t);
   endtask

   task automatic build_table();
      add_test(4, 0, pat_ramp);
      add_test(4, 0, pat_zero);
      add_test(8, 0, pat_const);
      add_test(6, 1000, pat_random);
      add_test(16, 40000, pat_random);
      add_test(3, 7, pat_random);
      // Image ends on the last memory word
      add_test(12, mem_words - 144, pat_ramp);
      add_test(1, 5, pat_const);
      add_test(16, 77, pat_random);
      add_test(10, 77, pat_random);
   endtask

   function automatic string pattern_label(input pattern_t pat);
      case (pat)
         pat_ramp:  return "ramp";
         pat_const: return "constant";
         pat_zero:  return "zero";
         default:   return "random";
      endcase
   endfunction

   task automatic fill_image(input test_entry_t t);
      int start;
      int total;
      int lo;
      int hi;
      int a;
      int off;
      start = int'(t.start_addr);
      total = int'(t.img_dim) * int'(t.img_dim);
      // Random surroundings so stray reads would spoil the sums
      if (t.pattern == pat_random)
      begin
         lo = (start > margin) ? start - margin : 0;
         hi = (start + total + margin < mem_words) ? start + total + margin : mem_words;
         for (a = lo; a < hi; a++)
            mem_model.mem[a] = pix_t'($random(seed));
      end
      for (off = 0; off < total; off++)
      begin
         case (t.pattern)
            pat_ramp:  mem_model.mem[start + off] = pix_t'(off ^ (off >> 8));
            pat_const: mem_model.mem[start + off] = pix_t'(const_pix);
            pat_zero:  mem_model.mem[start + off] = '0;
            default:   mem_model.mem[start + off] = pix_t'($random(seed));
         endcase
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   task automatic compute_expected(input test_entry_t t, output moments_t m,
                                   output centroid_t c);
      longint s00;
      longint s10;
      longint s01;
      int     dim;
      int     start;
      int     x;
      int     y;
      pix_t   p;
      dim   = int'(t.img_dim);
      start = int'(t.start_addr);
      s00   = 0;
      s10   = 0;
      s01   = 0;
      for (y = 0; y < dim; y++)
      begin
         for (x = 0; x < dim; x++)
         begin
            p   = mem_model.mem[start + y * dim + x];
            s00 += longint'(p);
            s10 += longint'(x) * longint'(p);
            s01 += longint'(y) * longint'(p);
         end
      end
      // Sums wrap at the accumulator width
      m.m00 = moment_t'(s00);
      m.m10 = moment_t'(s10);
      m.m01 = moment_t'(s01);
      if (m.m00 == '0)
         c = '0;
      else
      begin
         c.x_mc = cent_t'((longint'(m.m10) << `DESKEW_FRAC_W) / longint'(m.m00));
         c.y_mc = cent_t'((longint'(m.m01) << `DESKEW_FRAC_W) / longint'(m.m00));
      end
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_moments(input string name, input moments_t got, input moments_t exp);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s got m00/m10/m01 %0d/%0d/%0d, expected %0d/%0d/%0d",
                  $time, name, got.m00, got.m10, got.m01, exp.m00, exp.m10, exp.m01);
         errors++;
      end
   endtask

   task automatic check_centroid(input string name, input centroid_t got,
                                 input centroid_t exp);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s got x_mc %0d y_mc %0d, expected x_mc %0d y_mc %0d",
                  $time, name, got.x_mc, got.y_mc, exp.x_mc, exp.y_mc);
         errors++;
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s got %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
      begin
         $display("FAILED at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   //////////////////////////////
   // Host side
   //////////////////////////////

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_ack_level(input logic level, input int limit, output int cycles,
                                 output bit ok);
      cycles = 0;
      while (ack !== level && cycles < limit)
      begin
         next_cycle();
         cycles++;
      end
      ok = (ack === level);
   endtask

   task automatic run_test(input int idx, output bit hung);
      test_entry_t t;
      moments_t    exp_m;
      moments_t    held_m;
      centroid_t   exp_c;
      centroid_t   held_c;
      int          start_errors;
      int          cycles;
      int          n;
      bit          ok;
      t            = table_q[idx];
      start_errors = errors;
      hung         = 1'b0;
      fill_image(t);
      compute_expected(t, exp_m, exp_c);

      window_lo   = t.start_addr;
      window_hi   = t.start_addr + addr_t'(t.img_dim) * addr_t'(t.img_dim) - 1'b1;
      read_count  = 0;
      stray_reads = 0;
      window_on   = 1'b1;

      // Configuration settles a cycle before the request
      cfg.img_dim    = t.img_dim;
      cfg.start_addr = t.start_addr;
      next_cycle();
      req = 1'b1;

      wait_ack_level(1'b1, ack_timeout, cycles, ok);
      if (!ok)
      begin
         $display("Timeout in test %0d: ack_o did not rise within %0d cycles", idx,
                  ack_timeout);
         errors++;
         hung = 1'b1;
      end
      else
      begin
         window_on = 1'b0;
         check_moments("moments_o", moments, exp_m);
         check_centroid("centroid_o", centroid, exp_c);
         check_count("pixel reads", read_count, int'(t.img_dim) * int'(t.img_dim));
         if (stray_reads != 0)
         begin
            $display("Test %0d read %0d pixels outside the image window", idx, stray_reads);
            errors++;
         end

         // Results hold while the host keeps req high
         held_m = moments;
         held_c = centroid;
         for (n = 0; n < hold_cycles; n++)
         begin
            next_cycle();
            check_level("ack_o", ack, 1'b1);
            check_moments("moments_o", moments, held_m);
            check_centroid("centroid_o", centroid, held_c);
         end

         req = 1'b0;
         wait_ack_level(1'b0, fall_limit, cycles, ok);
         if (!ok)
         begin
            $display("Timeout in test %0d: ack_o stayed high after req_i fell", idx);
            errors++;
            hung = 1'b1;
         end
         else
            check_count("ack_o fall latency", cycles, 1);
      end

      tests_run++;
      if (errors > start_errors)
         tests_failed++;
      $display("Test %0d: %0dx%0d at %0d, %s pattern, %s", idx, t.img_dim, t.img_dim,
               t.start_addr, pattern_label(t.pattern),
               (errors > start_errors) ? "failed" : "passed");
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      int cycles;
      int i;
      bit hung;
      seed         = 65416;
      req          = 1'b0;
      cfg          = '0;
      window_on    = 1'b0;
      window_lo    = '0;
      window_hi    = '0;
      read_count   = 0;
      stray_reads  = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      hung         = 1'b0;
      build_table();

      cycles = 0;
      while (rst_n !== 1'b1 && cycles < reset_limit)
      begin
         @(posedge clk);
         cycles++;
      end

      if (rst_n !== 1'b1)
      begin
         $display("Timeout: reset was never released");
         errors++;
      end
      else
      begin
         next_cycle();
         check_level("ack_o", ack, 1'b0);
         i = 0;
         while (i < table_q.size() && !hung)
         begin
            run_test(i, hung);
            i++;
         end
      end

      $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
               tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* flist.f */
+incdir+hw
hw/moment_pkg.sv
hw/cfg_regs.sv
hw/raster_addr_gen.sv
hw/sync_fifo.sv
hw/moment_accum.sv
hw/centroid_divider.sv
hw/moment_engine_top.sv
testbench/tb_clk_gen.sv
testbench/tb_pixel_mem.sv
testbench/tb_top.sv

/* Bender.yml */
package:
  name: moment_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/moment_pkg.sv
      - hw/cfg_regs.sv
      - hw/raster_addr_gen.sv
      - hw/sync_fifo.sv
      - hw/moment_accum.sv
      - hw/centroid_divider.sv
      - hw/moment_engine_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_pixel_mem.sv
      - testbench/tb_top.sv
